/* compile.f */
logic/ecc_mem_pkg.sv
logic/axil_decode.sv
logic/ecc_execute.sv
logic/ecc_ram.sv
logic/ecc_result.sv
logic/ecc_mem_top.sv
tb/ecc_mem_properties.sv
tb/ecc_mem_tb.sv

/* run.sh */
#!/bin/sh
# build the ECC memory testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ecc_mem_tb -f compile.f \
    -o ecc_mem_sim > build.log 2>&1 && ./obj_dir/ecc_mem_sim > sim.log 2>&1
grep -q "Finished with no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb/ecc_mem_tb.sv */
// testbench for the ECC word memory that runs random AXI4-Lite traffic against a reference model.
`timescale 1ns/1ps

module ecc_mem_tb
    import ecc_mem_pkg::*;
();

    localparam int num_ops    = 400;
    localparam int timeout_ns = (num_ops + 10) * 20 * 10;  // 20 cycles of 10 ns per operation.

    logic        clk;
    logic        rst_n;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    axi_resp_e   bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    axi_resp_e   rresp;
    integer      seed;

    logic [31:0] model_data [256];
    int          model_class [256];  // number of flipped bits stored with the word.
    bit          model_written [256];
    int          written_q [$];
    logic [38:0] model_mask;         // pending injection mask with the check bits on top.
    logic [31:0] exp_corr;
    logic [31:0] exp_uncorr;

    ecc_mem_top #(
        .mem_addr_w (8)
    ) ecc_mem_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    always #5 clk = ~clk;

    ////////////////////
    // checks.
    task automatic report_mismatch(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic check_write(input axi_resp_e exp_resp, input axi_resp_e got_resp);
        if (got_resp != exp_resp) begin
            report_mismatch($sformatf("bresp %0d, expected %0d", got_resp, exp_resp));
        end
    endtask

    // read data only counts when the response is okay.
    task automatic check_read(input logic [31:0] exp_data, input axi_resp_e exp_resp,
                              input logic [31:0] got_data, input axi_resp_e got_resp);
        if (got_resp != exp_resp) begin
            report_mismatch($sformatf("rresp %0d, expected %0d", got_resp, exp_resp));
        end else if (exp_resp == resp_okay && got_data !== exp_data) begin
            report_mismatch($sformatf("rdata %h, expected %h", got_data, exp_data));
        end
    endtask

    task automatic check_latency(input int got_cycles);
        if (got_cycles != 2) begin
            report_mismatch($sformatf("response after %0d cycles, expected 2", got_cycles));
        end
    endtask

    ////////////////////
    // AXI4-Lite driver.
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axi_resp_e resp);
        int delay;
        int held;
        int lat;
        delay   = $unsigned($random(seed)) % 4;
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        bready  <= (delay == 0);
        do begin
            @(posedge clk);
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        lat  = 0;
        held = 0;
        @(posedge clk);
        while (!(bvalid && bready)) begin
            if (bvalid) begin
                held++;
                if (held >= delay) bready <= 1'b1;  // ready comes late and the response waits.
            end else begin
                lat++;
            end
            @(posedge clk);
        end
        resp   = bresp;
        bready <= 1'b0;
        check_latency(lat);
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        int delay;
        int held;
        int lat;
        delay   = $unsigned($random(seed)) % 4;
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= (delay == 0);
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        lat  = 0;
        held = 0;
        @(posedge clk);
        while (!(rvalid && rready)) begin
            if (rvalid) begin
                held++;
                if (held >= delay) rready <= 1'b1;
            end else begin
                lat++;
            end
            @(posedge clk);
        end
        data   = rdata;
        resp   = rresp;
        rready <= 1'b0;
        check_latency(lat);
    endtask

    // random upper bits alias onto the same word, bit 12 stays clear for memory space.
    function automatic logic [31:0] word_to_addr(input logic [7:0] word);
        logic [31:0] noise;
        noise = $random(seed);
        return (noise & 32'hFFFF_EC00) | {22'b0, word, 2'b00};
    endfunction

    ////////////////////
    // operations with model update.
    task automatic write_word(input logic [3:0] strb);
        logic [7:0]  word;
        logic [31:0] data;
        axi_resp_e   resp;
        word = 8'($random(seed));
        data = $random(seed);
        axi_write(word_to_addr(word), data, strb, resp);
        if (strb != 4'hF) begin
            check_write(resp_slverr, resp);  // nothing stored and the mask stays pending.
        end else begin
            check_write(resp_okay, resp);
            if (!model_written[word]) written_q.push_back(int'(word));
            model_written[word] = 1'b1;
            model_data[word]    = data;
            model_class[word]   = $countones(model_mask);
            model_mask          = '0;
        end
    endtask

    task automatic read_word();
        logic [7:0]  word;
        logic [31:0] data;
        axi_resp_e   resp;
        word = 8'(written_q[$unsigned($random(seed)) % written_q.size()]);
        axi_read(word_to_addr(word), data, resp);
        if (model_class[word] == 2) begin
            check_read(model_data[word], resp_slverr, data, resp);
            exp_uncorr = exp_uncorr + 32'd1;
        end else begin
            check_read(model_data[word], resp_okay, data, resp);
            if (model_class[word] == 1) exp_corr = exp_corr + 32'd1;
        end
    endtask

    task automatic load_mask();
        int          pos_a;
        int          pos_b;
        int          nbits;
        axi_resp_e   resp;
        nbits = $unsigned($random(seed)) % 3;
        pos_a = $unsigned($random(seed)) % 39;
        pos_b = (pos_a + 1 + $unsigned($random(seed)) % 38) % 39;  // never the same bit.
        model_mask = '0;
        if (nbits > 0) model_mask[pos_a] = 1'b1;
        if (nbits > 1) model_mask[pos_b] = 1'b1;
        axi_write(reg_base | reg_inj_data, model_mask[31:0], 4'hF, resp);
        check_write(resp_okay, resp);
        axi_write(reg_base | reg_inj_check, {25'b0, model_mask[38:32]}, 4'hF, resp);
        check_write(resp_okay, resp);
    endtask

    task automatic access_counter(input logic [31:0] offset, input bit is_write);
        logic [31:0] data;
        axi_resp_e   resp;
        if (is_write) begin
            axi_write(reg_base | offset, $random(seed), 4'hF, resp);  // ignored by the DUT.
            check_write(resp_okay, resp);
        end else begin
            axi_read(reg_base | offset, data, resp);
            check_read((offset == reg_cnt_corr) ? exp_corr : exp_uncorr, resp_okay, data, resp);
        end
    endtask

    ////////////////////
    // main sequence.
    initial begin
        int choice;
        clk     = 1'b0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        seed    = 30259;
        model_mask = '0;
        exp_corr   = '0;
        exp_uncorr = '0;
        for (int i = 0; i < 256; i++) begin
            model_written[i] = 1'b0;
            model_class[i]   = 0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < num_ops; i++) begin
            choice = $unsigned($random(seed)) % 16;
            if (choice >= 6 && choice <= 10 && written_q.size() == 0) choice = 0;
            if (choice <= 4) write_word(4'hF);
            else if (choice == 5) write_word(4'($unsigned($random(seed)) % 15));
            else if (choice <= 10) read_word();
            else if (choice <= 12) load_mask();
            else if (choice == 13) access_counter(reg_cnt_corr, 1'b1);
            else if (choice == 14) access_counter(reg_cnt_corr, 1'b0);
            else access_counter(reg_cnt_uncorr, 1'b0);
        end
        access_counter(reg_cnt_corr, 1'b0);
        access_counter(reg_cnt_uncorr, 1'b0);
        if (ecc_mem_top_inst.ecc_mem_properties_inst.fail_count != 0) begin
            $display("%0d handshake assertions failed during the run",
                     ecc_mem_top_inst.ecc_mem_properties_inst.fail_count);
            $display("Finished with errors");
            $fatal(1, "assertion failures");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the DUT did not finish the traffic within %0d ns", timeout_ns);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/ecc_mem_properties.sv */
// AXI4-Lite response and reset checks for the ECC word memory top level.
`timescale 1ns/1ps

module ecc_mem_properties
    import ecc_mem_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        wready,
    input logic        bvalid,
    input logic        bready,
    input axi_resp_e   bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input axi_resp_e   rresp,
    input logic        cmd_valid,
    input logic        exec_valid,
    input logic        ram_cs
);

    int unsigned fail_count = 0;  // number of failed assertions.

    ////////////////////
    // response channels.
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("bvalid or bresp changed before bready");
            fail_count++;
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("rvalid or its payload changed before rready");
            fail_count++;
        end

    one_resp: assert property (@(posedge clk) disable iff (!rst_n) !(bvalid && rvalid))
        else begin
            $error("bvalid and rvalid high together");
            fail_count++;
        end

    aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
        else begin
            $error("awready and wready differ");
            fail_count++;
        end

    // nothing is in flight right after reset.
    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !bvalid && !rvalid && !cmd_valid && !exec_valid && !ram_cs)
        else begin
            $error("valid high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind ecc_mem_top ecc_mem_properties ecc_mem_properties_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .awready    (awready),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .cmd_valid  (cmd_valid),
    .exec_valid (exec_valid),
    .ram_cs     (ram_cs)
);

/* logic/ecc_mem_top.sv */
// top level of the ECC word memory that joins the AXI4-Lite front end, execute, RAM and result.
`timescale 1ns/1ps

module ecc_mem_top
    import ecc_mem_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_w_max-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_w-1:0]     wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output axi_resp_e             bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_w_max-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [data_w-1:0]     rdata,
    output axi_resp_e             rresp
);

    mem_cmd_t              cmd;
    logic                  cmd_valid;
    logic                  done;
    mem_cmd_t              exec_cmd;
    logic                  exec_valid;
    logic                  ram_cs;
    logic                  ram_we;
    logic [mem_addr_w-1:0] ram_addr;
    ecc_code_u             ram_din;
    ecc_code_u             ram_dout;

    axil_decode axil_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .done      (done),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    ecc_execute #(
        .mem_addr_w (mem_addr_w)
    ) ecc_execute_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .ram_cs     (ram_cs),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_din    (ram_din),
        .exec_cmd   (exec_cmd),
        .exec_valid (exec_valid)
    );

    ecc_ram #(
        .mem_addr_w (mem_addr_w)
    ) ecc_ram_inst (
        .clk  (clk),
        .cs   (ram_cs),
        .we   (ram_we),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

    ecc_result ecc_result_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_cmd   (exec_cmd),
        .exec_valid (exec_valid),
        .ram_dout   (ram_dout),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .done       (done)
    );

endmodule

/* logic/ecc_result.sv */
// response stage that checks and corrects read codewords, counts errors and drives R and B.
`timescale 1ns/1ps

module ecc_result
    import ecc_mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  mem_cmd_t          exec_cmd,
    input  logic              exec_valid,
    input  ecc_code_u         ram_dout,
    output logic              bvalid,
    input  logic              bready,
    output axi_resp_e         bresp,
    output logic              rvalid,
    input  logic              rready,
    output logic [data_w-1:0] rdata,
    output axi_resp_e         rresp,
    output logic              done
);

    logic [check_w-1:0] syn;
    logic [5:0]         flip_idx;
    ecc_code_u          fixed;
    logic               err_single;
    logic               err_double;
    logic               mem_rd;
    logic [31:0]        cnt_corr;
    logic [31:0]        cnt_uncorr;
    logic [data_w-1:0]  rd_data;
    axi_resp_e          rd_resp;

    ////////////////////
    // syndrome check.
    always_comb begin
        syn      = ecc_syndrome(ram_dout);
        flip_idx = syndrome_to_bit(syn[ham_w-1:0]);
        fixed    = ram_dout;
        // odd parity means one flip, as long as the syndrome names a real bit.
        err_single = syn[check_w-1] && (syn[ham_w-1:0] < code_w);
        err_double = (syn != '0) && !err_single;
        if (err_single) begin
            fixed.flat[flip_idx] = ~fixed.flat[flip_idx];
        end
    end

    assign mem_rd = exec_valid && (exec_cmd.op == op_rd) && (exec_cmd.space == space_mem);

    always_comb begin
        rd_data = '0;
        rd_resp = resp_okay;
        if (exec_cmd.space == space_reg) begin
            case (exec_cmd.reg_sel)
                reg_cnt_corr[3:2]:   rd_data = cnt_corr;
                reg_cnt_uncorr[3:2]: rd_data = cnt_uncorr;
                default:             rd_data = '0;  // mask registers are write only.
            endcase
        end else if (err_double) begin
            rd_data = ram_dout.f.data;  // raw data goes back with the error.
            rd_resp = resp_slverr;
        end else begin
            rd_data = fixed.f.data;
        end
    end

    ////////////////////
    // response channels.
    assign done = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            cnt_corr   <= '0;
            cnt_uncorr <= '0;
        end else begin
            if (done) begin
                bvalid <= 1'b0;
                rvalid <= 1'b0;
            end
            if (exec_valid) begin
                if (exec_cmd.op == op_wr) begin
                    bvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end
            if (mem_rd && err_single) begin
                cnt_corr <= cnt_corr + 32'd1;
            end
            if (mem_rd && err_double) begin
                cnt_uncorr <= cnt_uncorr + 32'd1;  // no scrub, so a bad word counts on every read.
            end
        end
    end

    // payload is captured once and held while the valid waits for ready.
    always_ff @(posedge clk) begin
        if (exec_valid) begin
            bresp <= exec_cmd.strobe_ok ? resp_okay : resp_slverr;
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

/* logic/ecc_ram.sv */
// synchronous single-port codeword RAM with one cycle of read latency.
`timescale 1ns/1ps

module ecc_ram
    import ecc_mem_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  cs,
    input  logic                  we,
    input  logic [mem_addr_w-1:0] addr,
    input  ecc_code_u             din,
    output ecc_code_u             dout
);

    localparam int depth = 2 ** mem_addr_w;

    ecc_code_u             mem [depth];
    logic [mem_addr_w-1:0] read_addr;

    always_ff @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= din;
        end
    end

    // the held read address is lost on a write, so a read must be reissued.
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                read_addr <= 'x;
            end else begin
                read_addr <= addr;
            end
        end
    end

    assign dout = mem[read_addr];

endmodule

/* logic/ecc_execute.sv */
// command execution stage that encodes write data, applies injection masks and drives the RAM.
`timescale 1ns/1ps

module ecc_execute
    import ecc_mem_pkg::*;
#(
    parameter int mem_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_cmd_t              cmd,
    input  logic                  cmd_valid,
    output logic                  ram_cs,
    output logic                  ram_we,
    output logic [mem_addr_w-1:0] ram_addr,
    output ecc_code_u             ram_din,
    output mem_cmd_t              exec_cmd,
    output logic                  exec_valid
);

    logic [data_w-1:0]  inj_data;   // one-shot flip mask over the data field.
    logic [check_w-1:0] inj_check;  // one-shot flip mask over the check field.
    ecc_code_u          enc;
    ecc_code_u          mask;
    logic               mem_wr;
    logic               reg_wr;

    always_comb begin
        mem_wr = cmd_valid && (cmd.space == space_mem) && (cmd.op == op_wr) && cmd.strobe_ok;
        reg_wr = cmd_valid && (cmd.space == space_reg) && (cmd.op == op_wr) && cmd.strobe_ok;
        enc         = ecc_encode(cmd.wdata);
        mask.f.data  = inj_data;
        mask.f.check = inj_check;
    end

    ////////////////////
    // RAM port.
    // Partial strobes never reach the array.
    assign ram_cs   = cmd_valid && (cmd.space == space_mem) && (cmd.op == op_rd || cmd.strobe_ok);
    assign ram_we   = (cmd.op == op_wr);
    assign ram_addr = cmd.word_addr[mem_addr_w-1:0];
    assign ram_din  = enc.flat ^ mask.flat;

    ////////////////////
    // injection masks.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inj_data  <= '0;
            inj_check <= '0;
        end else if (mem_wr) begin
            // the mask is spent on this write.
            inj_data  <= '0;
            inj_check <= '0;
        end else if (reg_wr) begin
            case (cmd.reg_sel)
                reg_inj_data[3:2]:  inj_data  <= cmd.wdata;
                reg_inj_check[3:2]: inj_check <= cmd.wdata[check_w-1:0];
                default: ;  // counters are read only.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            exec_cmd <= cmd;  // forwarded for every command, RAM access or not.
        end
    end

endmodule

/* logic/axil_decode.sv */
// AXI4-Lite address and write channel front end that issues one memory or register command.
`timescale 1ns/1ps

module axil_decode
    import ecc_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_w_max-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_w-1:0]     wdata,
    input  logic [3:0]            wstrb,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_w_max-1:0] araddr,
    input  logic                  done,
    output mem_cmd_t              cmd,
    output logic                  cmd_valid
);

    logic                  busy;      // one transaction in flight until its response completes.
    logic                  wr_take;
    logic                  rd_take;
    logic [addr_w_max-1:0] sel_addr;
    mem_cmd_t              next_cmd;

    ////////////////////
    // arbitration.
    // A write needs both channels at once, and any sign of a write blocks the read.
    assign awready = !busy && awvalid && wvalid;
    assign wready  = !busy && awvalid && wvalid;
    assign arready = !busy && arvalid && !awvalid && !wvalid;

    assign wr_take = awready;
    assign rd_take = arready;

    ////////////////////
    // command build.
    always_comb begin
        sel_addr           = wr_take ? awaddr : araddr;
        next_cmd.op        = wr_take ? op_wr : op_rd;
        next_cmd.space     = |(sel_addr & reg_base) ? space_reg : space_mem;
        next_cmd.reg_sel   = sel_addr[3:2];
        next_cmd.word_addr = sel_addr[addr_w_max-1:2];  // upper bits simply alias.
        next_cmd.wdata     = wdata;
        next_cmd.strobe_ok = wr_take ? &wstrb : 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= wr_take || rd_take;
            if (wr_take || rd_take) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;  // ready again in the cycle after the response handshake.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take || rd_take) begin
            cmd <= next_cmd;
        end
    end

endmodule

/* logic/ecc_mem_pkg.sv */
// shared widths, command and codeword types, and SECDED helpers for the ECC word memory.
package ecc_mem_pkg;

    localparam int data_w     = 32;
    localparam int check_w    = 7;
    localparam int code_w     = data_w + check_w;
    localparam int ham_w      = check_w - 1;  // hamming check bits, the rest is overall parity.
    localparam int addr_w_max = 32;

    ////////////////////
    // address map.
    localparam logic [31:0] reg_base       = 32'h0000_1000;
    localparam logic [31:0] reg_inj_data   = 32'h0000_0000;
    localparam logic [31:0] reg_inj_check  = 32'h0000_0004;
    localparam logic [31:0] reg_cnt_corr   = 32'h0000_0008;
    localparam logic [31:0] reg_cnt_uncorr = 32'h0000_000C;

    localparam logic op_rd     = 1'b0;
    localparam logic op_wr     = 1'b1;
    localparam logic space_mem = 1'b0;
    localparam logic space_reg = 1'b1;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic                    op;
        logic                    space;
        logic [1:0]              reg_sel;
        logic [addr_w_max-3:0]   word_addr;
        logic [data_w-1:0]       wdata;
        logic                    strobe_ok;
    } mem_cmd_t;

    // the codeword is flipped and corrected as a flat vector, and split into fields elsewhere.
    typedef union packed {
        logic [code_w-1:0] flat;
        struct packed {
            logic [check_w-1:0] check;
            logic [data_w-1:0]  data;
        } f;
    } ecc_code_u;

    ////////////////////
    // SECDED helpers.
    // data bits sit at the non power of two positions 3, 5, 6, 7, 9 and so on.
    function automatic logic [ham_w-1:0] hamming_bits(input logic [data_w-1:0] d);
        logic [ham_w-1:0] h;
        int unsigned      di;
        h  = '0;
        di = 0;
        for (int unsigned p = 1; p < code_w; p++) begin
            if ((p & (p - 1)) != 0) begin
                for (int k = 0; k < ham_w; k++) begin
                    if (p[k]) begin
                        h[k] = h[k] ^ d[di];
                    end
                end
                di++;
            end
        end
        return h;
    endfunction

    function automatic ecc_code_u ecc_encode(input logic [data_w-1:0] d);
        ecc_code_u        c;
        logic [ham_w-1:0] h;
        h         = hamming_bits(d);
        c.f.data  = d;
        c.f.check = {^{h, d}, h};  // overall parity makes the whole word even.
        return c;
    endfunction

    // bit check_w-1 of the result is the overall parity, odd on a single flip.
    function automatic logic [check_w-1:0] ecc_syndrome(input ecc_code_u c);
        logic [ham_w-1:0] h;
        h = hamming_bits(c.f.data) ^ c.f.check[ham_w-1:0];
        return {^c.flat, h};
    endfunction

    function automatic logic [5:0] syndrome_to_bit(input logic [ham_w-1:0] syn);
        int unsigned pos;
        int unsigned below;
        logic [5:0]  idx;
        pos   = syn;
        below = 0;
        idx   = 6'(code_w - 1);  // a zero syndrome points at the overall parity bit.
        if (pos != 0) begin
            for (int k = 0; k < ham_w; k++) begin
                if ((1 << k) <= pos) begin
                    below++;
                end
            end
            idx = 6'(pos - 1 - below);
            for (int k = 0; k < ham_w; k++) begin
                if (pos == (1 << k)) begin
                    idx = 6'(data_w + k);  // hamming check bits live above the data field.
                end
            end
        end
        return idx;
    endfunction

endpackage
